// File: hdl/decoder_pkg.sv
`default_nettype none

package decoder_pkg;

    localparam int DATA_W = 16;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [3:0]        reg_sel_t;

    localparam reg_sel_t REG_SEL_NONE = 4'd0;
    localparam reg_sel_t REG_SEL_IMM  = 4'd8;

    // operand fetch states
    typedef enum logic [2:0] {
        ST_INST       = 3'd0,
        ST_IO_ONE_ARG = 3'd1,
        ST_TWO_ARGA   = 3'd2,
        ST_TWO_ARGB   = 3'd3,
        ST_IO_ARGA    = 3'd4,
        ST_IO_ARGB    = 3'd5,
        ST_IO_OP      = 3'd6
    } state_t;

    // opcode words, the low byte doubles as the alu operation
    localparam word_t OP_NOP    = 16'h0000;
    localparam word_t OP_ADD_RR = 16'h0001;
    localparam word_t OP_SUB_RR = 16'h0002;
    localparam word_t OP_AND_RR = 16'h0003;
    localparam word_t OP_OR_RR  = 16'h0004;
    localparam word_t OP_NOT_RR = 16'h0005;
    localparam word_t OP_XOR_RR = 16'h0006;
    localparam word_t OP_ADD_RI = 16'h0101;
    localparam word_t OP_SUB_RI = 16'h0102;
    localparam word_t OP_AND_RI = 16'h0103;
    localparam word_t OP_OR_RI  = 16'h0104;
    localparam word_t OP_NOT_RI = 16'h0105;
    localparam word_t OP_XOR_RI = 16'h0106;
    localparam word_t OP_INC    = 16'h0010;
    localparam word_t OP_DEC    = 16'h0011;
    localparam word_t OP_JMP    = 16'h0020;
    localparam word_t OP_INT    = 16'h0030;
    localparam word_t OP_MOV_RR = 16'h00ff;
    localparam word_t OP_LOAD   = 16'h02ff;
    localparam word_t OP_MOV_RA = 16'h03fd;
    localparam word_t OP_PUSH   = 16'h03f9;
    localparam word_t OP_POP    = 16'h03fa;

    // io: bit0 write, bit1 bus lock
    typedef logic [1:0] io_code_t;
    // pc: bit0 set, bit1 output enable, bit2 lock
    typedef logic [2:0] pc_code_t;
    // dc: bit0 data out, bit1 data enable, bit2 address out, bit3 lock
    typedef logic [3:0] dc_code_t;
    // ct: bit6 soft interrupt effective, bits 11..7 soft interrupt number
    typedef logic [12:0] ct_code_t;
    // alu: op 18..11, second selector 10..7, first selector 6..3, io flags 2..0
    typedef logic [18:0] alu_code_t;
    typedef logic [2:0]  alu_io_t;

    localparam alu_io_t ALU_IO_NONE  = 3'b000;
    localparam alu_io_t ALU_IO_DC_IN = 3'b010;
    localparam alu_io_t ALU_IO_OUT   = 3'b011;

    localparam pc_code_t PC_FETCH = 3'b010;
    localparam pc_code_t PC_JUMP  = 3'b001;
    localparam pc_code_t PC_HOLD  = 3'b100;

    localparam dc_code_t DC_READ = 4'b0010;
    localparam dc_code_t DC_ADDR = 4'b0110;
    localparam dc_code_t DC_IDLE = 4'b0000;

    localparam io_code_t IO_WRITE = 2'b11;

endpackage

`default_nettype wire

// File: hdl/opcode_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_lookup
    import decoder_pkg::*;
(
    input  word_t  i_opcode,
    output state_t o_first_state
);

    // the number of words per instruction follows from the first state:
    // two-arg and io-one-arg take three words, io-arg takes four,
    // io-op alone takes two and inst alone takes one
    always_comb begin
        case (i_opcode)
            OP_ADD_RR,
            OP_SUB_RR,
            OP_AND_RR,
            OP_OR_RR,
            OP_NOT_RR,
            OP_XOR_RR: begin
                o_first_state = ST_TWO_ARGA;
            end
            OP_ADD_RI,
            OP_SUB_RI,
            OP_AND_RI,
            OP_OR_RI,
            OP_NOT_RI,
            OP_XOR_RI: begin
                o_first_state = ST_TWO_ARGA;
            end
            // register moves and loads
            OP_MOV_RR,
            OP_LOAD: begin
                o_first_state = ST_TWO_ARGA;
            end
            OP_INC,
            OP_DEC,
            OP_JMP: begin
                o_first_state = ST_TWO_ARGA;
            end
            // register to address, needs source and address words
            OP_MOV_RA: begin
                o_first_state = ST_IO_ARGA;
            end
            OP_PUSH,
            OP_POP: begin
                o_first_state = ST_IO_ONE_ARG;
            end
            // interrupt number follows directly
            OP_INT: begin
                o_first_state = ST_IO_OP;
            end
            OP_NOP: begin
                o_first_state = ST_INST;
            end
            // unknown words are skipped as one-word no-ops
            default: begin
                o_first_state = ST_INST;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/operand_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer
    import decoder_pkg::*;
(
    input  wire    clk,
    input  wire    n_rst,

    input  word_t  i_data,
    input  logic   i_lock,
    input  logic   i_interrupt,

    input  state_t i_first_state,

    output state_t o_state,
    output word_t  o_word,
    output word_t  o_opcode,
    output word_t  o_arga,
    output word_t  o_argb
);

    word_t  replay_q;
    word_t  word;
    state_t state_q;
    state_t state_d;
    word_t  opcode_q;
    word_t  arga_q;
    word_t  argb_q;

    // while locked the word seen last before the lock is replayed
    assign word = i_lock ? replay_q : i_data;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            replay_q <= '0;
        end else if (!i_lock) begin
            replay_q <= i_data;
        end
    end

    always_comb begin
        case (state_q)
            ST_INST:       state_d = i_first_state;
            ST_IO_ONE_ARG: state_d = ST_IO_OP;
            ST_TWO_ARGA:   state_d = ST_TWO_ARGB;
            ST_TWO_ARGB:   state_d = ST_INST;
            ST_IO_ARGA:    state_d = ST_IO_ARGB;
            ST_IO_ARGB:    state_d = ST_IO_OP;
            ST_IO_OP:      state_d = ST_INST;
            default:       state_d = ST_INST;
        endcase
    end

    // interrupt aborts whatever is in flight, even under lock
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= ST_INST;
        end else if (i_interrupt) begin
            state_q <= ST_INST;
        end else if (!i_lock) begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            opcode_q <= '0;
        end else if (!i_lock && state_q == ST_INST) begin
            opcode_q <= word;
        end
    end

    // first operand word
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            arga_q <= '0;
        end else if (!i_lock) begin
            case (state_q)
                ST_TWO_ARGA,
                ST_IO_ONE_ARG,
                ST_IO_ARGA: begin
                    arga_q <= word;
                end
                default: begin
                    arga_q <= arga_q;
                end
            endcase
        end
    end

    // second operand word, only the address of mov_ra
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            argb_q <= '0;
        end else if (!i_lock && state_q == ST_IO_ARGB) begin
            argb_q <= word;
        end
    end

    assign o_state  = state_q;
    assign o_word   = word;
    assign o_opcode = (state_q == ST_INST) ? word : opcode_q;
    assign o_arga   = arga_q;
    assign o_argb   = argb_q;

endmodule

`default_nettype wire

// File: hdl/control_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module control_encoder
    import decoder_pkg::*;
(
    input  state_t    i_state,
    input  word_t     i_opcode,
    input  word_t     i_word,
    input  word_t     i_arga,
    input  word_t     i_argb,

    output io_code_t  o_io_code,
    output pc_code_t  o_pc_code,
    output dc_code_t  o_dc_code,
    output ct_code_t  o_ct_code,
    output alu_code_t o_alu_code,
    output word_t     o_data_alu,
    output word_t     o_addr
);

    function automatic alu_code_t pack_alu(
        input logic [7:0] op,
        input reg_sel_t   sel2,
        input reg_sel_t   sel1,
        input alu_io_t    flags
    );
        pack_alu = {op, sel2, sel1, flags};
    endfunction

    logic [7:0] op;

    assign op = i_opcode[7:0];

    always_comb begin
        // fetch defaults, every state but the last one of an instruction
        o_io_code  = '0;
        o_pc_code  = PC_FETCH;
        o_dc_code  = DC_READ;
        o_ct_code  = '0;
        o_alu_code = '0;
        o_data_alu = '0;
        o_addr     = '0;

        case (i_state)
            ST_TWO_ARGB: begin
                case (i_opcode)
                    OP_ADD_RR,
                    OP_SUB_RR,
                    OP_AND_RR,
                    OP_OR_RR,
                    OP_NOT_RR,
                    OP_XOR_RR,
                    OP_MOV_RR: begin
                        o_alu_code = pack_alu(op, i_word[3:0], i_arga[3:0], ALU_IO_NONE);
                    end
                    // immediate comes in through the decoder data path
                    OP_ADD_RI,
                    OP_SUB_RI,
                    OP_AND_RI,
                    OP_OR_RI,
                    OP_NOT_RI,
                    OP_XOR_RI: begin
                        o_alu_code = pack_alu(op, REG_SEL_IMM, i_arga[3:0], ALU_IO_DC_IN);
                    end
                    // arga carries the value, the final word names the target
                    OP_LOAD: begin
                        o_alu_code = pack_alu(op, REG_SEL_NONE, i_word[3:0], ALU_IO_DC_IN);
                        o_data_alu = i_arga;
                    end
                    OP_INC,
                    OP_DEC: begin
                        o_alu_code = pack_alu(op, REG_SEL_NONE, i_arga[3:0], ALU_IO_NONE);
                    end
                    OP_JMP: begin
                        o_pc_code = PC_JUMP;
                        o_dc_code = DC_ADDR;
                        o_addr    = i_word;
                    end
                    default: begin
                        o_alu_code = '0;
                    end
                endcase
            end
            ST_IO_OP: begin
                case (i_opcode)
                    OP_MOV_RA: begin
                        o_io_code  = IO_WRITE;
                        o_pc_code  = PC_HOLD;
                        o_dc_code  = DC_ADDR;
                        o_alu_code = pack_alu(op, REG_SEL_NONE, i_arga[3:0], ALU_IO_OUT);
                        o_addr     = i_argb;
                    end
                    // stack access, address comes from the stack pointer
                    OP_PUSH: begin
                        o_io_code  = IO_WRITE;
                        o_pc_code  = PC_HOLD;
                        o_dc_code  = DC_IDLE;
                        o_alu_code = pack_alu(op, REG_SEL_NONE, i_arga[3:0], ALU_IO_OUT);
                    end
                    OP_POP: begin
                        o_pc_code  = PC_HOLD;
                        o_dc_code  = DC_IDLE;
                        o_alu_code = pack_alu(op, REG_SEL_NONE, i_arga[3:0], ALU_IO_DC_IN);
                    end
                    // soft interrupt number is taken from the final word
                    OP_INT: begin
                        o_ct_code[6]    = 1'b1;
                        o_ct_code[11:7] = i_word[4:0];
                    end
                    default: begin
                        o_ct_code = '0;
                    end
                endcase
            end
            default: begin
                o_alu_code = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/inst_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder_top
    import decoder_pkg::*;
(
    input  wire       clk,
    input  wire       n_rst,

    input  word_t     i_data,
    input  logic      i_lock,
    input  logic      i_interrupt,

    output io_code_t  o_io_code,
    output pc_code_t  o_pc_code,
    output dc_code_t  o_dc_code,
    output ct_code_t  o_ct_code,
    output alu_code_t o_alu_code,
    output word_t     o_data_alu,
    output word_t     o_addr
);

    state_t first_state;
    state_t state;
    word_t  word;
    word_t  opcode;
    word_t  arga;
    word_t  argb;

    // decode sees the effective word straight from the sequencer
    opcode_lookup u_lookup (
        .i_opcode      (word),
        .o_first_state (first_state)
    );

    operand_sequencer u_sequencer (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_data        (i_data),
        .i_lock        (i_lock),
        .i_interrupt   (i_interrupt),
        .i_first_state (first_state),
        .o_state       (state),
        .o_word        (word),
        .o_opcode      (opcode),
        .o_arga        (arga),
        .o_argb        (argb)
    );

    control_encoder u_encoder (
        .i_state    (state),
        .i_opcode   (opcode),
        .i_word     (word),
        .i_arga     (arga),
        .i_argb     (argb),
        .o_io_code  (o_io_code),
        .o_pc_code  (o_pc_code),
        .o_dc_code  (o_dc_code),
        .o_ct_code  (o_ct_code),
        .o_alu_code (o_alu_code),
        .o_data_alu (o_data_alu),
        .o_addr     (o_addr)
    );

endmodule

`default_nettype wire

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input logic [72:0] expected,
                           input logic [72:0] actual);
    if (expected !== actual) begin
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
        abort_run("output mismatch");
    end
endtask

task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (n_rst !== 1'b1) begin
        if (cycles >= 20) begin
            abort_run("timeout while waiting for reset release");
        end else begin
            @(posedge clk);
            cycles++;
        end
    end
endtask

// one word per cycle with the outputs sampled 1 ns after the falling edge
task automatic step(input string name, input word_t data, input logic lock,
                    input logic intr);
    word_t w;
    @(negedge clk);
    i_data      = data;
    i_lock      = lock;
    i_interrupt = intr;
    #1;
    w = lock ? m_replay : data;
    check_value(name, model_outputs(m_state, w), dut_vec);
    model_clock(data, lock, intr);
endtask

task automatic test_alu_ops();
    word_t ops [16];
    int    i;
    ops = '{OP_ADD_RR, OP_SUB_RR, OP_AND_RR, OP_OR_RR, OP_NOT_RR, OP_XOR_RR,
            OP_ADD_RI, OP_SUB_RI, OP_AND_RI, OP_OR_RI, OP_NOT_RI, OP_XOR_RI,
            OP_MOV_RR, OP_LOAD, OP_INC, OP_DEC};
    for (i = 0; i < 16; i++) begin
        step("alu_ops", ops[i[3:0]], 1'b0, 1'b0);
        step("alu_ops", 16'h0a50 + 16'(i), 1'b0, 1'b0);
        step("alu_ops", 16'h0003, 1'b0, 1'b0);
    end
    // value beef into register 2
    step("alu_ops", OP_LOAD, 1'b0, 1'b0);
    step("alu_ops", 16'hbeef, 1'b0, 1'b0);
    step("alu_ops", 16'h0002, 1'b0, 1'b0);
    check_value("alu_ops load alu", 73'({8'hff, 4'h0, 4'h2, 3'b010}), 73'(o_alu_code));
    check_value("alu_ops load data", 73'(16'hbeef), 73'(o_data_alu));
endtask

task automatic test_jump();
    step("jump", OP_JMP, 1'b0, 1'b0);
    step("jump", 16'h0000, 1'b0, 1'b0);
    step("jump", 16'h1a2c, 1'b0, 1'b0);
    check_value("jump pc", 73'(3'b001), 73'(o_pc_code));
    check_value("jump dc", 73'(4'b0110), 73'(o_dc_code));
    check_value("jump addr", 73'(16'h1a2c), 73'(o_addr));
endtask

task automatic test_io_ops();
    step("io_ops", OP_MOV_RA, 1'b0, 1'b0);
    step("io_ops", 16'h0007, 1'b0, 1'b0);
    step("io_ops", 16'h4000, 1'b0, 1'b0);
    step("io_ops", 16'h5555, 1'b0, 1'b0);
    check_value("io_ops mov_ra io", 73'(2'b11), 73'(o_io_code));
    check_value("io_ops mov_ra alu", 73'({8'hfd, 4'h0, 4'h7, 3'b011}), 73'(o_alu_code));
    check_value("io_ops mov_ra addr", 73'(16'h4000), 73'(o_addr));
    step("io_ops", OP_PUSH, 1'b0, 1'b0);
    step("io_ops", 16'h0009, 1'b0, 1'b0);
    step("io_ops", 16'h0000, 1'b0, 1'b0);
    check_value("io_ops push alu", 73'({8'hf9, 4'h0, 4'h9, 3'b011}), 73'(o_alu_code));
    step("io_ops", OP_POP, 1'b0, 1'b0);
    step("io_ops", 16'h0004, 1'b0, 1'b0);
    step("io_ops", 16'h0000, 1'b0, 1'b0);
    check_value("io_ops pop pc", 73'(3'b100), 73'(o_pc_code));
    check_value("io_ops pop alu", 73'({8'hfa, 4'h0, 4'h4, 3'b010}), 73'(o_alu_code));
    step("io_ops", OP_INT, 1'b0, 1'b0);
    step("io_ops", 16'h0015, 1'b0, 1'b0);
    check_value("io_ops int ct", 73'(13'h0ac0), 73'(o_ct_code));
endtask

task automatic test_lock();
    step("lock", OP_SUB_RR, 1'b0, 1'b0);
    step("lock", 16'hdead, 1'b1, 1'b0);
    step("lock", 16'hbeef, 1'b1, 1'b0);
    step("lock", 16'h0004, 1'b0, 1'b0);
    // the final word stays locked for two cycles and the selector comes from the replayed 0004
    step("lock", 16'hffff, 1'b1, 1'b0);
    step("lock", 16'h1234, 1'b1, 1'b0);
    check_value("lock replay alu", 73'({8'h02, 4'h4, 4'h4, 3'b000}), 73'(o_alu_code));
    step("lock", 16'h0007, 1'b0, 1'b0);
    check_value("lock release alu", 73'({8'h02, 4'h7, 4'h4, 3'b000}), 73'(o_alu_code));
endtask

task automatic test_interrupt_and_unknown();
    step("interrupt", OP_MOV_RA, 1'b0, 1'b0);
    step("interrupt", 16'h0002, 1'b0, 1'b1);
    step("interrupt", OP_ADD_RR, 1'b0, 1'b0);
    step("interrupt", 16'h0001, 1'b0, 1'b0);
    step("interrupt", 16'h0006, 1'b0, 1'b0);
    check_value("interrupt add_rr alu", 73'({8'h01, 4'h6, 4'h1, 3'b000}), 73'(o_alu_code));
    step("unknown", 16'h7777, 1'b0, 1'b0);
    step("unknown", OP_INC, 1'b0, 1'b0);
    step("unknown", 16'h0006, 1'b0, 1'b0);
    step("unknown", 16'h0000, 1'b0, 1'b0);
    check_value("unknown inc alu", 73'({8'h10, 4'h0, 4'h6, 3'b000}), 73'(o_alu_code));
endtask

task automatic test_random_stream();
    word_t pool [32];
    int    n;
    int    k;
    pool = '{OP_ADD_RR, OP_SUB_RR, OP_AND_RR, OP_OR_RR, OP_NOT_RR, OP_XOR_RR,
             OP_ADD_RI, OP_SUB_RI, OP_AND_RI, OP_OR_RI, OP_NOT_RI, OP_XOR_RI,
             OP_MOV_RR, OP_LOAD, OP_INC, OP_DEC, OP_JMP, OP_INT, OP_MOV_RA,
             OP_PUSH, OP_POP, OP_NOP, 16'h1234, 16'h00fe, 16'h0007, 16'h0201,
             OP_MOV_RA, OP_PUSH, OP_POP, OP_INT, OP_JMP, OP_LOAD};
    for (n = 0; n < 300; n++) begin
        rng = lcg_next(rng);
        step("random_stream", pool[rng[20:16]], 1'b0, 1'b0);
        k = 0;
        while (m_state != ST_INST) begin
            if (k >= 8) begin
                abort_run("instruction in the random stream did not finish");
            end else begin
                rng = lcg_next(rng);
                step("random_stream", rng[31:16], 1'b0, 1'b0);
                k++;
            end
        end
    end
endtask

`endif

// File: test/tb_inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_inst_decoder
    import decoder_pkg::*;
();

    logic        clk;
    logic        n_rst;
    word_t       i_data;
    logic        i_lock;
    logic        i_interrupt;
    io_code_t    o_io_code;
    pc_code_t    o_pc_code;
    dc_code_t    o_dc_code;
    ct_code_t    o_ct_code;
    alu_code_t   o_alu_code;
    word_t       o_data_alu;
    word_t       o_addr;
    logic [72:0] dut_vec;

    // reference copy of the fetch state and operand registers
    state_t      m_state;
    word_t       m_opcode;
    word_t       m_arga;
    word_t       m_argb;
    word_t       m_replay;
    logic [31:0] rng;

    inst_decoder_top i_dut (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_data      (i_data),
        .i_lock      (i_lock),
        .i_interrupt (i_interrupt),
        .o_io_code   (o_io_code),
        .o_pc_code   (o_pc_code),
        .o_dc_code   (o_dc_code),
        .o_ct_code   (o_ct_code),
        .o_alu_code  (o_alu_code),
        .o_data_alu  (o_data_alu),
        .o_addr      (o_addr)
    );

    assign dut_vec = {o_io_code, o_pc_code, o_dc_code, o_ct_code,
                      o_alu_code, o_data_alu, o_addr};

    initial clk = 1'b0;
    always #2 clk = ~clk;

    initial begin
        n_rst = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // high byte 00 is the register form, 01 the immediate form
    function automatic logic is_alu(input word_t w, input logic [7:0] form);
        return (w[15:8] == form) && (w[7:0] >= 8'd1) && (w[7:0] <= 8'd6);
    endfunction

    function automatic state_t model_first_state(input word_t w);
        if (is_alu(w, 8'h00) || is_alu(w, 8'h01))
            return ST_TWO_ARGA;
        case (w)
            OP_MOV_RR, OP_LOAD, OP_INC, OP_DEC, OP_JMP: return ST_TWO_ARGA;
            OP_MOV_RA: return ST_IO_ARGA;
            OP_PUSH, OP_POP: return ST_IO_ONE_ARG;
            OP_INT: return ST_IO_OP;
            default: return ST_INST;
        endcase
    endfunction

    // expected {io, pc, dc, ct, alu, data_alu, addr} for one cycle
    function automatic logic [72:0] model_outputs(input state_t st, input word_t w);
        io_code_t   io;
        pc_code_t   pc;
        dc_code_t   dc;
        ct_code_t   ct;
        alu_code_t  alu;
        word_t      dat;
        word_t      adr;
        logic [7:0] op;
        io  = 2'b00;
        pc  = PC_FETCH;
        dc  = DC_READ;
        ct  = '0;
        alu = '0;
        dat = '0;
        adr = '0;
        op  = m_opcode[7:0];
        if (st == ST_TWO_ARGB) begin
            if (is_alu(m_opcode, 8'h00) || m_opcode == OP_MOV_RR) begin
                alu = {op, w[3:0], m_arga[3:0], ALU_IO_NONE};
            end else if (is_alu(m_opcode, 8'h01)) begin
                alu = {op, REG_SEL_IMM, m_arga[3:0], ALU_IO_DC_IN};
            end else if (m_opcode == OP_LOAD) begin
                alu = {op, 4'h0, w[3:0], ALU_IO_DC_IN};
                dat = m_arga;
            end else if (m_opcode == OP_INC || m_opcode == OP_DEC) begin
                alu = {op, 4'h0, m_arga[3:0], ALU_IO_NONE};
            end else if (m_opcode == OP_JMP) begin
                pc  = PC_JUMP;
                dc  = DC_ADDR;
                adr = w;
            end
        end else if (st == ST_IO_OP) begin
            if (m_opcode == OP_MOV_RA || m_opcode == OP_PUSH) begin
                io  = IO_WRITE;
                pc  = PC_HOLD;
                dc  = DC_IDLE;
                alu = {op, 4'h0, m_arga[3:0], ALU_IO_OUT};
            end else if (m_opcode == OP_POP) begin
                pc  = PC_HOLD;
                dc  = DC_IDLE;
                alu = {op, 4'h0, m_arga[3:0], ALU_IO_DC_IN};
            end else if (m_opcode == OP_INT) begin
                ct[6]    = 1'b1;
                ct[11:7] = w[4:0];
            end
            if (m_opcode == OP_MOV_RA) begin
                dc  = DC_ADDR;
                adr = m_argb;
            end
        end
        return {io, pc, dc, ct, alu, dat, adr};
    endfunction

    // register updates at the rising edge
    task automatic model_clock(input word_t data, input logic lock, input logic intr);
        if (!lock) begin
            if (m_state == ST_INST)
                m_opcode = data;
            if (m_state == ST_TWO_ARGA || m_state == ST_IO_ONE_ARG || m_state == ST_IO_ARGA)
                m_arga = data;
            if (m_state == ST_IO_ARGB)
                m_argb = data;
            m_replay = data;
        end
        if (intr) begin
            m_state = ST_INST;
        end else if (!lock) begin
            case (m_state)
                ST_INST:                   m_state = model_first_state(data);
                ST_TWO_ARGA:               m_state = ST_TWO_ARGB;
                ST_IO_ARGA:                m_state = ST_IO_ARGB;
                ST_IO_ONE_ARG, ST_IO_ARGB: m_state = ST_IO_OP;
                default:                   m_state = ST_INST;
            endcase
        end
    endtask

    `include "tb_checks.svh"

    initial begin
        i_data      = '0;
        i_lock      = 1'b0;
        i_interrupt = 1'b0;
        rng         = 32'd54498;
        m_state     = ST_INST;
        m_opcode    = '0;
        m_arga      = '0;
        m_argb      = '0;
        m_replay    = '0;
        wait_reset_release();
        test_alu_ops();
        test_jump();
        test_io_ops();
        test_lock();
        test_interrupt_and_unknown();
        test_random_stream();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/decoder_pkg.sv
hdl/opcode_lookup.sv
hdl/operand_sequencer.sv
hdl/control_encoder.sv
hdl/inst_decoder_top.sv
test/tb_inst_decoder.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_inst_decoder -f src.f -o sim_inst_decoder \
    && ./obj_dir/sim_inst_decoder | tee /dev/stderr \
    | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
